//--- all.f
+incdir+hw
hw/slave_rd_pkg.sv
hw/ddr_rd_pkg.sv
hw/ddr3_rd_burst_planner.sv
hw/ddr3_rd_width_fifo.sv
hw/ddr3_rd_beat_streamer.sv
hw/ddr3_read.sv
verification/ddr3_mem_model.sv
verification/tb_ddr3_read.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the DDR3 read front end with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_ddr3_read \
    -o sim_ddr3_read &&
./obj_dir/sim_ddr3_read &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

//--- verification/tb_ddr3_read.sv
`timescale 1ns/1ps
`include "ddr3_rd_params.svh"

module tb_ddr3_read;

    logic                       clk = 1'b0;
    logic                       ddr_rstn_sync;
    slave_rd_pkg::rd_addr_req_t rd_addr_req;
    logic                       rd_addr_valid;
    logic                       rd_addr_ready;
    slave_rd_pkg::rd_beat_t     rd_beat;
    logic                       rd_data_valid;
    logic                       rd_data_ready;
    ddr_rd_pkg::ddr_rd_cmd_t    ddr_cmd;
    logic                       ddr_cmd_valid;
    logic                       ddr_cmd_ready;
    ddr_rd_pkg::ddr_rd_data_t   ddr_data;
    logic                       ddr_data_valid;
    logic [31:0]                model_rnd;

    slave_rd_pkg::rd_beat_t     exp_q[$];
    slave_rd_pkg::rd_beat_t     exp_head;
    int                         exp_count;
    string                      test_name;
    logic [`DDR_ADDR_W-1:0]     exp_cmd_addr;  // next command address
    logic [`RD_ID_W-1:0]        exp_cmd_id;    // id of the request being served
    int                         words_left;    // lines still to be requested
    int                         since_last;    // cycles after the last beat
    logic                       job_open;      // between acceptance and the last beat
    int                         ready_mode;    // 0 always, 1 random, 2 mostly stalled
    logic [31:0]                stim_seed;
    logic [31:0]                hs_seed;

    ddr3_read ddr3_read_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .rd_addr_req   (rd_addr_req),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .rd_beat       (rd_beat),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .ddr_cmd       (ddr_cmd),
        .ddr_cmd_valid (ddr_cmd_valid),
        .ddr_cmd_ready (ddr_cmd_ready),
        .ddr_data      (ddr_data),
        .ddr_data_valid(ddr_data_valid)
    );

    ddr3_mem_model mem_model_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .ddr_cmd       (ddr_cmd),
        .ddr_cmd_valid (ddr_cmd_valid),
        .ddr_cmd_ready (ddr_cmd_ready),
        .ddr_data      (ddr_data),
        .ddr_data_valid(ddr_data_valid),
        .rnd           (model_rnd)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    // expected memory word at a 32-bit word address
    function automatic logic [`BEAT_W-1:0] expected_word(input logic [`DDR_ADDR_W-1:0] a);
        return {4'hA, a};
    endfunction

    task automatic fail_value(input string what, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
        $display("** Error: %s, %s: expected %h, actual %h", test_name, what, exp_v, act_v);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic fail_msg(input string what);
        $display("Error in %s: %s", test_name, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic refresh_head();
        exp_count = exp_q.size();
        if (exp_count > 0) exp_head = exp_q[0];
        else exp_head = '0;
    endtask

    // handshake randomness for both sides on the falling edge
    always @(negedge clk) begin
        hs_seed = lcg_next(hs_seed);
        model_rnd <= hs_seed;
        if (ready_mode == 0) rd_data_ready <= 1'b1;
        else if (ready_mode == 1) rd_data_ready <= (hs_seed[17:16] != 2'b00);
        else rd_data_ready <= (hs_seed[18:16] == 3'b000);
    end

    // reference bookkeeping on pre-edge values
    always @(posedge clk) begin
        if (ddr_rstn_sync) begin
            if (rd_addr_valid && rd_addr_ready) job_open = 1'b1;
            if (ddr_cmd_valid && ddr_cmd_ready) begin
                exp_cmd_addr = exp_cmd_addr
                             + `DDR_ADDR_W'((int'(ddr_cmd.len) + 1) * `WORDS_PER_LINE);
                words_left   = words_left - (int'(ddr_cmd.len) + 1);
            end
            if (since_last == 3) since_last = 0;
            else if (since_last != 0) since_last = since_last + 1;
            if (rd_data_valid && rd_data_ready) begin
                if (rd_beat.last) begin
                    since_last = 1;
                    job_open   = 1'b0;
                end
                if (exp_q.size() > 0) void'(exp_q.pop_front());
                refresh_head();
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        $rose(ddr_rstn_sync) |-> (rd_addr_ready && !rd_data_valid && !ddr_cmd_valid))
        else fail_msg("channels not idle after reset");

    a_beat: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (rd_data_valid && rd_data_ready) |-> (exp_count > 0 && rd_beat == exp_head))
        else fail_value("beat {id,data,last}", {27'b0, $sampled(exp_head)},
                        {27'b0, $sampled(rd_beat)});

    a_beat_hold: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (rd_data_valid && !rd_data_ready) |=> (rd_data_valid && $stable(rd_beat)))
        else fail_msg("beat changed or vanished while waiting for ready");

    a_cmd_hold: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (ddr_cmd_valid && !ddr_cmd_ready) |=> (ddr_cmd_valid && $stable(ddr_cmd)))
        else fail_msg("command changed or vanished while waiting for ready");

    a_cmd_addr: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (ddr_cmd_valid && ddr_cmd_ready) |-> (ddr_cmd.addr == exp_cmd_addr))
        else fail_value("command address", 64'($sampled(exp_cmd_addr)),
                        64'($sampled(ddr_cmd.addr)));

    a_cmd_id: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (ddr_cmd_valid && ddr_cmd_ready) |-> (ddr_cmd.id == exp_cmd_id))
        else fail_value("command id", 64'($sampled(exp_cmd_id)),
                        64'($sampled(ddr_cmd.id)));

    a_cmd_len: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (ddr_cmd_valid && ddr_cmd_ready) |-> ((int'(ddr_cmd.len) + 1) <= words_left))
        else fail_value("command words within span", 64'($sampled(words_left)),
                        64'(int'($sampled(ddr_cmd.len)) + 1));

    a_span: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (rd_data_valid && rd_data_ready && rd_beat.last) |-> (words_left == 0))
        else fail_value("lines left unrequested", 64'd0, 64'($sampled(words_left)));

    a_busy: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        job_open |-> !rd_addr_ready)
        else fail_msg("rd_addr_ready high while a request is in flight");

    a_end_low: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (since_last == 1 || since_last == 2) |-> !rd_addr_ready)
        else fail_msg("rd_addr_ready rose too early after the last beat");

    a_end_high: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        (since_last == 3) |-> rd_addr_ready)
        else fail_msg("rd_addr_ready not high 2 cycles after the last beat");

    // called and returns on a falling edge
    task automatic send_req(input logic [`RD_ID_W-1:0] id, input logic [`DDR_ADDR_W-1:0] addr,
                            input logic [`RD_LEN_W-1:0] len);
        int                     t;
        slave_rd_pkg::rd_beat_t b;
        rd_addr_req.id   = id;
        rd_addr_req.addr = addr;
        rd_addr_req.len  = len;
        rd_addr_valid    = 1'b1;
        t = 0;
        while (!rd_addr_ready) begin
            @(negedge clk);
            t++;
            if (t > 20000) fail_msg("timeout waiting for rd_addr_ready");
        end
        // accepted on the coming rising edge
        exp_cmd_addr = {addr[`DDR_ADDR_W-1:`LINE_SEL_W], `LINE_SEL_W'(0)};
        exp_cmd_id   = id;
        words_left   = int'((addr + `DDR_ADDR_W'(len)) >> `LINE_SEL_W)
                     - int'(addr >> `LINE_SEL_W) + 1;
        for (int k = 0; k <= int'(len); k++) begin
            b.id   = id;
            b.data = expected_word(addr + `DDR_ADDR_W'(k));
            b.last = (k == int'(len));
            exp_q.push_back(b);
        end
        refresh_head();
        @(negedge clk);
        rd_addr_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (exp_q.size() != 0 || !rd_addr_ready) begin
            @(negedge clk);
            t++;
            if (t > 20000) fail_msg("timeout waiting for the request to complete");
        end
    endtask

    initial begin
        logic [31:0]            r;
        logic [`DDR_ADDR_W-1:0] a;
        ddr_rstn_sync = 1'b0;
        rd_addr_valid = 1'b0;
        rd_addr_req   = '0;
        rd_data_ready = 1'b0;
        model_rnd     = '0;
        ready_mode    = 0;
        stim_seed     = 32'd87;
        hs_seed       = lcg_next(32'd87);
        words_left    = 0;
        exp_cmd_addr  = '0;
        exp_cmd_id    = '0;
        since_last    = 0;
        job_open      = 1'b0;
        test_name     = "reset";
        refresh_head();
        repeat (10) @(negedge clk);
        ddr_rstn_sync = 1'b1;
        @(negedge clk);

        test_name = "aligned_short";
        for (int n = 1; n <= 8; n++) begin
            r = next_rand();
            a = {1'b0, r[30:7], 3'b000};
            send_req(r[3:0], a, 8'(n - 1));
            wait_idle();
        end

        test_name = "unaligned";
        for (int off = 1; off <= 7; off++) begin
            r = next_rand();
            a = {1'b0, r[30:7], 3'(off)};
            send_req(r[3:0], a, 8'(7) + 8'(r[6:4]));  // always crosses a line
            wait_idle();
        end

        test_name = "long_256";
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            a = {1'b0, r[30:4]};
            send_req(r[3:0], a, 8'd255);
            wait_idle();
        end

        test_name = "random_ready";
        ready_mode = 1;
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            a = {1'b0, r[30:4]};
            send_req(r[3:0], a, r[31:24]);
            wait_idle();
        end
        ready_mode = 2;  // long stalls fill the FIFO
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            a = {1'b0, r[30:4]};
            send_req(r[3:0], a, 8'd255);
            wait_idle();
        end

        test_name = "back_to_back";
        ready_mode = 1;
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            a = {1'b0, r[30:4]};
            send_req(4'(i + 3), a, {3'b000, r[31:27]});
        end
        wait_idle();

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verification/ddr3_mem_model.sv
`timescale 1ns/1ps
`include "ddr3_rd_params.svh"

module ddr3_mem_model (
    input  logic                     clk,
    input  logic                     ddr_rstn_sync,
    input  ddr_rd_pkg::ddr_rd_cmd_t  ddr_cmd,
    input  logic                     ddr_cmd_valid,
    output logic                     ddr_cmd_ready,
    output ddr_rd_pkg::ddr_rd_data_t ddr_data,
    output logic                     ddr_data_valid,
    input  logic [31:0]              rnd  // fresh random bits every falling edge
);

    ddr_rd_pkg::ddr_rd_cmd_t cmd_q;
    int                      fire_cnt;
    int                      served_cnt;
    int                      gap;  // idle cycles before the next word
    logic                    busy;
    logic [`DDR_ADDR_W-1:0]  line_addr;
    logic [`DDR_LEN_W-1:0]   words_left;
    logic [`RD_ID_W-1:0]     id_q;

    // memory content: 0xA in the top nibble, the word address below
    function automatic logic [`BEAT_W-1:0] pattern(input logic [`DDR_ADDR_W-1:0] a);
        return {4'hA, a};
    endfunction

    function automatic logic [`DDR_DATA_W-1:0] line_data(input logic [`DDR_ADDR_W-1:0] base);
        logic [`DDR_DATA_W-1:0] d;
        d = '0;
        for (int j = 0; j < `WORDS_PER_LINE; j++) begin
            d[j*`BEAT_W +: `BEAT_W] = pattern(base + `DDR_ADDR_W'(j));
        end
        return d;
    endfunction

    // command handshake seen on the rising edge
    always @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            fire_cnt <= 0;
        end else if (ddr_cmd_valid && ddr_cmd_ready) begin
            fire_cnt <= fire_cnt + 1;
            cmd_q    <= ddr_cmd;
        end
    end

    always @(negedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            ddr_cmd_ready  = 1'b0;
            ddr_data_valid = 1'b0;
            ddr_data       = '0;
            busy           = 1'b0;
            served_cnt     = 0;
            gap            = 0;
            line_addr      = '0;
            words_left     = '0;
            id_q           = '0;
        end else begin
            ddr_data_valid = 1'b0;
            if (!busy && (fire_cnt != served_cnt)) begin
                busy       = 1'b1;
                served_cnt = served_cnt + 1;
                line_addr  = cmd_q.addr;
                words_left = cmd_q.len;
                id_q       = cmd_q.id;
                gap        = int'(rnd[11:8]);  // first word latency
            end else if (busy) begin
                if (gap > 0) begin
                    gap = gap - 1;
                end else begin
                    ddr_data.data  = line_data(line_addr);
                    ddr_data.id    = id_q;
                    ddr_data.last  = (words_left == '0);
                    ddr_data_valid = 1'b1;
                    if (words_left == '0) begin
                        busy = 1'b0;
                    end else begin
                        words_left = words_left - 1'b1;
                        line_addr  = line_addr + `DDR_ADDR_W'(`WORDS_PER_LINE);
                        gap        = (rnd[13:12] == 2'b11) ? 1 : 0;  // occasional bubble
                    end
                end
            end
            ddr_cmd_ready = !busy && (fire_cnt == served_cnt) && (rnd[1:0] != 2'b00);
        end
    end

endmodule

//--- hw/ddr3_read.sv
`timescale 1ns/1ps
`include "ddr3_rd_params.svh"

module ddr3_read (
    input  logic                       clk,
    input  logic                       ddr_rstn_sync,

    // slave address channel
    input  slave_rd_pkg::rd_addr_req_t rd_addr_req,
    input  logic                       rd_addr_valid,
    output logic                       rd_addr_ready,

    // slave data channel
    output slave_rd_pkg::rd_beat_t     rd_beat,
    output logic                       rd_data_valid,
    input  logic                       rd_data_ready,

    // DDR3 controller side
    output ddr_rd_pkg::ddr_rd_cmd_t    ddr_cmd,
    output logic                       ddr_cmd_valid,
    input  logic                       ddr_cmd_ready,
    input  ddr_rd_pkg::ddr_rd_data_t   ddr_data,
    input  logic                       ddr_data_valid
);

    slave_rd_pkg::rd_job_t   job;
    logic                    job_start;
    logic                    job_done;
    logic                    flush;
    logic [`FIFO_LVL_W-1:0]  fifo_level;
    logic                    pop;
    logic                    head_valid;
    logic [`BEAT_W-1:0]      head_data;
    logic                    ddr_data_last_seen;

    assign ddr_data_last_seen = ddr_data_valid & ddr_data.last;

    ddr3_rd_burst_planner burst_planner_i (
        .clk                (clk),
        .ddr_rstn_sync      (ddr_rstn_sync),
        .rd_addr_req        (rd_addr_req),
        .rd_addr_valid      (rd_addr_valid),
        .rd_addr_ready      (rd_addr_ready),
        .ddr_cmd            (ddr_cmd),
        .ddr_cmd_valid      (ddr_cmd_valid),
        .ddr_cmd_ready      (ddr_cmd_ready),
        .ddr_data_last_seen (ddr_data_last_seen),
        .fifo_level         (fifo_level),
        .job_start          (job_start),
        .job                (job),
        .job_done           (job_done)
    );

    ddr3_rd_width_fifo width_fifo_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .flush         (flush),
        .wr_valid      (ddr_data_valid),  // room guaranteed by the planner
        .wr_data       (ddr_data.data),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .fifo_level    (fifo_level)
    );

    ddr3_rd_beat_streamer beat_streamer_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .job_start     (job_start),
        .job           (job),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .pop           (pop),
        .rd_beat       (rd_beat),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .job_done      (job_done),
        .flush         (flush)
    );

endmodule

//--- hw/ddr3_rd_beat_streamer.sv
`timescale 1ns/1ps
`include "ddr3_rd_params.svh"

module ddr3_rd_beat_streamer (
    input  logic                   clk,
    input  logic                   ddr_rstn_sync,
    input  logic                   job_start,
    input  slave_rd_pkg::rd_job_t  job,
    input  logic                   head_valid,
    input  logic [`BEAT_W-1:0]     head_data,
    output logic                   pop,
    output slave_rd_pkg::rd_beat_t rd_beat,
    output logic                   rd_data_valid,
    input  logic                   rd_data_ready,
    output logic                   job_done,
    output logic                   flush
);

    logic                   busy;
    logic [`LINE_SEL_W-1:0] drop_left;   // leading words still to discard
    logic [`RD_LEN_W-1:0]   beats_left;  // beats after the current one
    logic [`RD_ID_W-1:0]    id_q;
    logic                   end_q;
    logic                   dropping;
    logic                   drop_pop;
    logic                   beat_xfer;
    logic                   last_xfer;

    assign dropping = busy & (drop_left != '0);
    assign drop_pop = dropping & head_valid;

    // dropped words never reach the slave side
    assign rd_data_valid = busy & ~dropping & head_valid;
    assign beat_xfer     = rd_data_valid & rd_data_ready;
    assign last_xfer     = beat_xfer & (beats_left == '0);

    assign pop = drop_pop | beat_xfer;

    assign rd_beat.id   = id_q;
    assign rd_beat.data = head_data;
    assign rd_beat.last = (beats_left == '0);

    // the same pulse clears the FIFO tail
    assign flush = job_done;

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            busy       <= 1'b0;
            drop_left  <= '0;
            beats_left <= '0;
        end else if (job_start) begin
            busy       <= 1'b1;
            drop_left  <= job.drop;
            beats_left <= job.beats_m1;
        end else begin
            if (drop_pop) begin
                drop_left <= drop_left - 1'b1;
            end

            if (last_xfer) begin
                busy <= 1'b0;
            end else if (beat_xfer) begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    // last beat -> end_q -> job_done, ready returns one edge later
    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            end_q    <= 1'b0;
            job_done <= 1'b0;
        end else begin
            end_q    <= last_xfer;
            job_done <= end_q;
        end
    end

    always_ff @(posedge clk) begin
        if (job_start) begin
            id_q <= job.id;  // echoed on every beat
        end
    end

endmodule

//--- hw/ddr3_rd_width_fifo.sv
`timescale 1ns/1ps
`include "ddr3_rd_params.svh"

module ddr3_rd_width_fifo (
    input  logic                   clk,
    input  logic                   ddr_rstn_sync,
    input  logic                   flush,
    input  logic                   wr_valid,
    input  logic [`DDR_DATA_W-1:0] wr_data,
    input  logic                   pop,
    output logic                   head_valid,
    output logic [`BEAT_W-1:0]     head_data,
    output logic [`FIFO_LVL_W-1:0] fifo_level
);

    logic [`DDR_DATA_W-1:0] mem [`FIFO_WORDS];

    logic [`FIFO_PTR_W-1:0] wr_ptr;
    logic [`FIFO_PTR_W-1:0] rd_ptr;
    logic [`LINE_SEL_W-1:0] beat_sel;  // 32-bit word inside the head line
    logic                   do_write;
    logic                   do_pop;
    logic                   line_free;

    assign head_valid = (fifo_level != '0);

    // beat 0 sits in the low bits of the line
    assign head_data = mem[rd_ptr][beat_sel*`BEAT_W +: `BEAT_W];

    assign do_write  = wr_valid & ~flush;  // nothing is in flight during a flush
    assign do_pop    = pop & head_valid;
    assign line_free = do_pop & (beat_sel == `LINE_SEL_W'(`WORDS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            beat_sel   <= '0;
            fifo_level <= '0;
        end else if (flush) begin
            // drops any tail words of the finished request
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            beat_sel   <= '0;
            fifo_level <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            end

            if (line_free) begin
                beat_sel <= '0;
                rd_ptr   <= rd_ptr + 1'b1;
            end else if (do_pop) begin
                beat_sel <= beat_sel + 1'b1;
            end

            case ({do_write, line_free})
                2'b10:   fifo_level <= fifo_level + 1'b1;
                2'b01:   fifo_level <= fifo_level - 1'b1;
                default: fifo_level <= fifo_level;  // none, or one in and one out
            endcase
        end
    end

endmodule

//--- hw/ddr3_rd_burst_planner.sv
`timescale 1ns/1ps
`include "ddr3_rd_params.svh"

module ddr3_rd_burst_planner (
    input  logic                       clk,
    input  logic                       ddr_rstn_sync,
    input  slave_rd_pkg::rd_addr_req_t rd_addr_req,
    input  logic                       rd_addr_valid,
    output logic                       rd_addr_ready,
    output ddr_rd_pkg::ddr_rd_cmd_t    ddr_cmd,
    output logic                       ddr_cmd_valid,
    input  logic                       ddr_cmd_ready,
    input  logic                       ddr_data_last_seen,
    input  logic [`FIFO_LVL_W-1:0]     fifo_level,
    output logic                       job_start,
    output slave_rd_pkg::rd_job_t      job,
    input  logic                       job_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_CMD,
        ST_DATA
    } state_t;

    state_t state;
    state_t state_d;

    logic [`DDR_ADDR_W-1:0]             end_addr;
    logic [`DDR_ADDR_W-`LINE_SEL_W-1:0] line_diff;
    logic [`FIFO_LVL_W-1:0]             span_lines;
    logic [`FIFO_LVL_W-1:0]             lines_left;
    logic [`FIFO_LVL_W-1:0]             burst_lines;
    logic [`FIFO_LVL_W-1:0]             burst_len_m1;
    logic [`DDR_ADDR_W-1:0]             cmd_addr;
    logic [`RD_ID_W-1:0]                cmd_id;
    logic                               accept;
    logic                               cmd_fire;
    logic                               fifo_room;

    assign accept   = rd_addr_valid & rd_addr_ready;
    assign cmd_fire = ddr_cmd_valid & ddr_cmd_ready;

    // span in lines: last line index minus first line index, plus one
    assign end_addr   = rd_addr_req.addr + `DDR_ADDR_W'(rd_addr_req.len);
    assign line_diff  = end_addr[`DDR_ADDR_W-1:`LINE_SEL_W]
                      - rd_addr_req.addr[`DDR_ADDR_W-1:`LINE_SEL_W];
    assign span_lines = line_diff[`FIFO_LVL_W-1:0] + 1'b1;

    assign burst_lines  = (lines_left > `FIFO_LVL_W'(`MAX_DDR_BURST)) ?
                          `FIFO_LVL_W'(`MAX_DDR_BURST) : lines_left;
    assign burst_len_m1 = burst_lines - 1'b1;

    // a full burst must fit behind what is already buffered
    assign fifo_room = fifo_level <= `FIFO_LVL_W'(`FIFO_WORDS - `MAX_DDR_BURST);

    assign rd_addr_ready = (state == ST_IDLE);
    assign ddr_cmd_valid = (state == ST_CMD);
    assign ddr_cmd.addr  = cmd_addr;
    assign ddr_cmd.len   = burst_len_m1[`DDR_LEN_W-1:0];
    assign ddr_cmd.id    = cmd_id;

    assign job_start    = accept;
    assign job.drop     = rd_addr_req.addr[`LINE_SEL_W-1:0];
    assign job.beats_m1 = rd_addr_req.len;
    assign job.id       = rd_addr_req.id;

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE: begin
                if (accept) state_d = ST_WAIT;
            end
            ST_WAIT: begin
                if (job_done) begin
                    state_d = ST_IDLE;
                end else if ((lines_left != '0) && fifo_room) begin
                    state_d = ST_CMD;
                end
            end
            ST_CMD: begin
                if (cmd_fire) state_d = ST_DATA;  // command held until taken
            end
            ST_DATA: begin
                if (ddr_data_last_seen) state_d = ST_WAIT;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            state      <= ST_IDLE;
            lines_left <= '0;
        end else begin
            state <= state_d;
            if (accept) begin
                lines_left <= span_lines;
            end else if (cmd_fire) begin
                lines_left <= lines_left - burst_lines;
            end
        end
    end

    // next line aligned command address and the echoed id
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_addr <= {rd_addr_req.addr[`DDR_ADDR_W-1:`LINE_SEL_W], `LINE_SEL_W'(0)};
            cmd_id   <= rd_addr_req.id;
        end else if (cmd_fire) begin
            cmd_addr <= cmd_addr + `DDR_ADDR_W'(burst_lines * `WORDS_PER_LINE);
        end
    end

endmodule

//--- hw/ddr_rd_pkg.sv
`include "ddr3_rd_params.svh"

package ddr_rd_pkg;

    // read command to the DDR3 controller
    typedef struct packed {
        logic [`DDR_ADDR_W-1:0] addr;  // line aligned
        logic [`DDR_LEN_W-1:0]  len;   // words minus one
        logic [`RD_ID_W-1:0]    id;
    } ddr_rd_cmd_t;

    // word coming back from the controller, in order
    typedef struct packed {
        logic [`DDR_DATA_W-1:0] data;
        logic [`RD_ID_W-1:0]    id;
        logic                   last;  // final word of a command
    } ddr_rd_data_t;

endpackage

//--- hw/slave_rd_pkg.sv
`include "ddr3_rd_params.svh"

package slave_rd_pkg;

    // request on the slave address channel
    typedef struct packed {
        logic [`RD_ID_W-1:0]    id;
        logic [`DDR_ADDR_W-1:0] addr;  // in 32-bit words
        logic [`RD_LEN_W-1:0]   len;   // beats minus one
    } rd_addr_req_t;

    // one beat on the slave data channel
    typedef struct packed {
        logic [`RD_ID_W-1:0] id;
        logic [`BEAT_W-1:0]  data;
        logic                last;
    } rd_beat_t;

    // handed from planner to streamer at acceptance
    typedef struct packed {
        logic [`LINE_SEL_W-1:0] drop;      // leading words to skip in the first line
        logic [`RD_LEN_W-1:0]   beats_m1;
        logic [`RD_ID_W-1:0]    id;
    } rd_job_t;

endpackage

//--- hw/ddr3_rd_params.svh
`ifndef DDR3_RD_PARAMS_SVH
`define DDR3_RD_PARAMS_SVH

// word address into DDR3, counted in 32-bit words
`define DDR_ADDR_W      28
`define DDR_DATA_W      256  // controller word
`define BEAT_W          32   // slave beat
`define RD_ID_W         4
`define RD_LEN_W        8    // slave length minus one, up to 256 beats

// beats packed in one controller word
`define WORDS_PER_LINE  8
`define LINE_SEL_W      3

`define MAX_DDR_BURST   16   // controller words per command
`define DDR_LEN_W       4    // command length minus one

// read FIFO depth in controller words
`define FIFO_WORDS      32
`define FIFO_PTR_W      5
`define FIFO_LVL_W      6    // holds 0 to FIFO_WORDS

`endif
